//--- design/cmd_queue.sv
`default_nettype none

module cmd_queue
   import xbus_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic       cmd_valid,
   input  wire logic       cmd_write,
   input  wire xbus_addr_t cmd_addr,
   input  wire xbus_data_t cmd_data,
   output logic            cmd_credit,
   output logic            q_valid,
   output logic            q_write,
   output xbus_addr_t      q_addr,
   output xbus_data_t      q_data,
   input  wire logic       q_pop
);

   logic                    write_mem [CMD_DEPTH];
   xbus_addr_t              addr_mem  [CMD_DEPTH];
   xbus_data_t              data_mem  [CMD_DEPTH];

   logic [CMD_PTR_BITS-1:0] wr_ptr;
   logic [CMD_PTR_BITS-1:0] rd_ptr;
   logic [CMD_PTR_BITS:0]   count;                 // One bit wider to hold a full queue

   // Storage takes every push; credits keep the host from overrunning it
   always_ff @(posedge clk)
   begin
      if (cmd_valid)
      begin
         write_mem[wr_ptr] <= cmd_write;
         addr_mem[wr_ptr]  <= cmd_addr;
         data_mem[wr_ptr]  <= cmd_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         cmd_credit <= 1'b0;
      end
      else
      begin
         if (cmd_valid)
         begin
            wr_ptr <= wr_ptr + 1'b1;                // Depth is a power of two so pointers wrap
         end
         if (q_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         case ({cmd_valid, q_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // Push and pop together leave it unchanged
         endcase

         cmd_credit <= q_pop;                       // A freed slot goes back to the host
      end
   end

   assign q_valid = (count != '0);
   assign q_write = write_mem[rd_ptr];
   assign q_addr  = addr_mem[rd_ptr];
   assign q_data  = data_mem[rd_ptr];

endmodule

`default_nettype wire

//--- design/xbus_master.sv
`default_nettype none

module xbus_master
   import xbus_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       reset,

   input  wire logic       q_valid,
   input  wire logic       q_write,
   input  wire xbus_addr_t q_addr,
   input  wire xbus_data_t q_data,
   output logic            q_pop,

   output logic            req,
   output logic            write,
   output xbus_addr_t      addr,
   output xbus_data_t      datain,
   input  wire xbus_data_t dataout,
   input  wire logic       ack,
   input  wire logic       decode,

   output logic            rsp_valid,
   output xbus_data_t      rsp_data,
   output logic            rsp_nxm
);

   typedef enum logic [1:0]
   {
      IDLE,
      LOAD,
      BUS,
      RESPOND
   } master_state_t;

   master_state_t state;
   master_state_t next_state;

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (q_valid)
            begin
               next_state = LOAD;
            end
         end
         LOAD:
         begin
            if (decode)
            begin
               next_state = BUS;
            end
            else
            begin
               next_state = RESPOND;                // Nobody answers this address
            end
         end
         BUS:
         begin
            if (ack)
            begin
               next_state = RESPOND;
            end
         end
         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= next_state;
      end
   end

   assign q_pop     = (state == IDLE) && q_valid;
   assign req       = (state == BUS);              // Falls on the edge that samples ack
   assign rsp_valid = (state == RESPOND);

   // The bus side holds the popped command for the whole transaction
   always_ff @(posedge clk)
   begin
      if (q_pop)
      begin
         write  <= q_write;
         addr   <= q_addr;
         datain <= q_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == LOAD)
      begin
         rsp_nxm  <= ~decode;
         rsp_data <= '0;                            // Writes and nxm report zero
      end
      else if ((state == BUS) && ack && !write)
      begin
         rsp_data <= dataout;
      end
   end

endmodule

`default_nettype wire

//--- design/xbus_pkg.sv
`default_nettype none

package xbus_pkg;

   // Word address on the bus
   typedef logic [21:0] xbus_addr_t;

   // One bus data word
   typedef logic [31:0] xbus_data_t;

   // Words backed by real storage in the slave
   localparam int RAM_WORDS = 64;
   localparam int RAM_ADDR_BITS = 6;

   // Addresses from here upward are not decoded and end as nxm
   localparam xbus_addr_t DECODE_LIMIT = 22'o11000000;

   // Length of the acknowledge delay line in the slave
   localparam int ACK_STAGES = 7;

   // Queue entries, equal to the number of host credits
   localparam int CMD_DEPTH = 4;
   localparam int CMD_PTR_BITS = 2;

   // Read value for decoded addresses that have no storage behind them
   localparam xbus_data_t UNBACKED_DATA = 32'hffff_ffff;

endpackage

`default_nettype wire

//--- design/xbus_ram.sv
`default_nettype none

module xbus_ram
   import xbus_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire xbus_addr_t addr,
   input  wire xbus_data_t datain,
   input  wire logic       req,
   input  wire logic       write,
   output xbus_data_t      dataout,
   output logic            ack,
   output logic            decode
);

   xbus_data_t               ram [RAM_WORDS];

   logic [RAM_ADDR_BITS-1:0] ram_index;
   logic                     backed;
   logic                     req_delayed;
   logic [ACK_STAGES-1:0]    ack_delayed;
   logic                     busy;

   // Decoded space runs past the storage and the gap reads as all ones
   assign decode    = (addr < DECODE_LIMIT);
   assign backed    = (addr < xbus_addr_t'(RAM_WORDS));
   assign ram_index = addr[RAM_ADDR_BITS-1:0];

   assign busy = req_delayed || (ack_delayed != '0);
   assign ack  = ack_delayed[ACK_STAGES-1];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_delayed <= 1'b0;
         ack_delayed <= '0;
      end
      else
      begin
         req_delayed <= req && decode && !busy;     // One accept per transaction
         ack_delayed <= {ack_delayed[ACK_STAGES-2:0], req_delayed};
      end
   end

   // Storage write lands one cycle after the request is accepted
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < RAM_WORDS; i++)
         begin
            ram[i] <= '0;
         end
      end
      else if (req_delayed && write && backed)
      begin
         ram[ram_index] <= datain;                  // Unbacked writes fall away here
      end
   end

   assign dataout = backed ? ram[ram_index] : UNBACKED_DATA;

endmodule

`default_nettype wire

//--- design/xbus_subsystem.sv
`default_nettype none

module xbus_subsystem
   import xbus_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       reset,

   input  wire logic       cmd_valid,
   input  wire logic       cmd_write,
   input  wire xbus_addr_t cmd_addr,
   input  wire xbus_data_t cmd_data,
   output logic            cmd_credit,

   output logic            rsp_valid,
   output xbus_data_t      rsp_data,
   output logic            rsp_nxm
);

   // Queue head toward the master
   logic       q_valid;
   logic       q_write;
   xbus_addr_t q_addr;
   xbus_data_t q_data;
   logic       q_pop;

   // Bus between master and RAM slave
   logic       req;
   logic       write;
   xbus_addr_t addr;
   xbus_data_t datain;
   xbus_data_t dataout;
   logic       ack;
   logic       decode;

   cmd_queue u_cmd_queue (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_write  (cmd_write),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .cmd_credit (cmd_credit),
      .q_valid    (q_valid),
      .q_write    (q_write),
      .q_addr     (q_addr),
      .q_data     (q_data),
      .q_pop      (q_pop)
   );

   xbus_master u_xbus_master (
      .clk       (clk),
      .reset     (reset),
      .q_valid   (q_valid),
      .q_write   (q_write),
      .q_addr    (q_addr),
      .q_data    (q_data),
      .q_pop     (q_pop),
      .req       (req),
      .write     (write),
      .addr      (addr),
      .datain    (datain),
      .dataout   (dataout),
      .ack       (ack),
      .decode    (decode),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .rsp_nxm   (rsp_nxm)
   );

   xbus_ram u_xbus_ram (
      .clk     (clk),
      .reset   (reset),
      .addr    (addr),
      .datain  (datain),
      .req     (req),
      .write   (write),
      .dataout (dataout),
      .ack     (ack),
      .decode  (decode)
   );

endmodule

`default_nettype wire

//--- filelist.f
design/xbus_pkg.sv
design/cmd_queue.sv
design/xbus_master.sv
design/xbus_ram.sv
design/xbus_subsystem.sv
tb/xbus_tb.sv

//--- tb/xbus_tb.sv
`default_nettype none

module xbus_tb
   import xbus_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_CMDS         = 300;
   localparam int TIMEOUT_CYCLES   = NUM_CMDS * (ACK_STAGES + 8) + 200;
   localparam int ISOLATED_LATENCY = ACK_STAGES + 4;
   localparam int UNBACKED_SPAN    = int'(DECODE_LIMIT) - RAM_WORDS;
   localparam int NXM_SPAN         = (1 << 22) - int'(DECODE_LIMIT);

   logic        clk;
   logic        reset;
   logic        cmd_valid;
   logic        cmd_write;
   xbus_addr_t  cmd_addr;
   xbus_data_t  cmd_data;
   logic        cmd_credit;
   logic        rsp_valid;
   xbus_data_t  rsp_data;
   logic        rsp_nxm;

   logic [31:0] lfsr_state;
   int          cycle_count = 0;
   int          credits;
   int          issued;
   int          responses;
   int          data_errors;
   int          nxm_errors;
   int          latency_errors;
   int          credit_errors;
   int          order_errors;
   bit          wait_idle;

   xbus_data_t  model_mem [RAM_WORDS];
   xbus_data_t  exp_data_q [$];
   logic        exp_nxm_q [$];
   int          exp_edge_q [$];
   bit          exp_timed_q [$];

   xbus_subsystem dut (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_write  (cmd_write),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .cmd_credit (cmd_credit),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .rsp_nxm    (rsp_nxm)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;              // Edge number for latency checks
   end

   // Taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   function automatic logic [31:0] random_bits(input int width);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < width; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   task automatic compare_data(input xbus_data_t actual, input xbus_data_t expected,
                               input string what);
      if (actual !== expected)
      begin
         data_errors++;
         $display("FAIL %0d ns: %s data expected %h, got %h", $time, what, expected, actual);
      end
   endtask

   task automatic compare_nxm(input logic actual, input logic expected, input string what);
      if (actual !== expected)
      begin
         nxm_errors++;
         $display("FAIL %0d ns: %s nxm expected %b, got %b", $time, what, expected, actual);
      end
   endtask

   task automatic compare_latency(input int actual, input int expected, input string what);
      if (actual != expected)
      begin
         latency_errors++;
         $display("FAIL %0d ns: %s latency expected %0d, got %0d", $time, what, expected,
                  actual);
      end
   endtask

   task automatic check_credits();
      if (credits < 0 || credits > CMD_DEPTH)
      begin
         credit_errors++;
         $display("Host credit count is %0d at %0d ns, outside 0 to %0d", credits, $time,
                  CMD_DEPTH);
      end
   endtask

   // Picks a random command, predicts its response and drives it for the next edge
   task automatic issue_command(input bit timed);
      logic       write;
      logic [1:0] addr_class;
      int         offset;
      xbus_addr_t addr;
      xbus_data_t data;
      xbus_data_t expected;
      logic       nxm;
      write      = random_bits(1);
      addr_class = random_bits(2);
      data       = random_bits(32);
      offset     = int'(random_bits(21));
      case (addr_class)
         2'd1:    addr = xbus_addr_t'(RAM_WORDS + offset % UNBACKED_SPAN);
         2'd2:    addr = xbus_addr_t'(int'(DECODE_LIMIT) + offset % NXM_SPAN);
         default: addr = xbus_addr_t'(offset % RAM_WORDS);   // Two classes in four hit storage
      endcase

      nxm      = (addr >= DECODE_LIMIT);
      expected = '0;
      if (!nxm && !write)
      begin
         expected = (addr < RAM_WORDS) ? model_mem[addr[RAM_ADDR_BITS-1:0]] : UNBACKED_DATA;
      end
      else if (!nxm && write && addr < RAM_WORDS)
      begin
         model_mem[addr[RAM_ADDR_BITS-1:0]] = data;
      end

      exp_data_q.push_back(expected);
      exp_nxm_q.push_back(nxm);
      exp_edge_q.push_back(cycle_count + 1);
      exp_timed_q.push_back(timed && !nxm);        // Only decoded commands have a fixed latency

      cmd_valid = 1'b1;
      cmd_write = write;
      cmd_addr  = addr;
      cmd_data  = data;
      credits--;
      issued++;
   endtask

   task automatic check_response();
      xbus_data_t exp_data;
      logic       exp_nxm;
      int         exp_edge;
      bit         timed;
      if (rsp_valid)
      begin
         if (exp_data_q.size() == 0)
         begin
            order_errors++;
            $display("A response arrived at %0d ns with no command outstanding", $time);
         end
         else
         begin
            exp_data = exp_data_q.pop_front();
            exp_nxm  = exp_nxm_q.pop_front();
            exp_edge = exp_edge_q.pop_front();
            timed    = exp_timed_q.pop_front();
            compare_data(rsp_data, exp_data, $sformatf("response %0d", responses));
            compare_nxm(rsp_nxm, exp_nxm, $sformatf("response %0d", responses));
            if (timed)
            begin
               compare_latency(cycle_count - exp_edge, ISOLATED_LATENCY,
                               $sformatf("response %0d", responses));
            end
            responses++;
         end
      end
   endtask

   initial
   begin
      clk            = 1'b0;
      reset          = 1'b1;
      cmd_valid      = 1'b0;
      cmd_write      = 1'b0;
      cmd_addr       = '0;
      cmd_data       = '0;
      lfsr_state     = 32'heb51;
      credits        = CMD_DEPTH;
      issued         = 0;
      responses      = 0;
      data_errors    = 0;
      nxm_errors     = 0;
      latency_errors = 0;
      credit_errors  = 0;
      order_errors   = 0;
      for (int i = 0; i < RAM_WORDS; i++)
      begin
         model_mem[i] = '0;
      end

      repeat (5) @(negedge clk);
      reset     = 1'b0;
      wait_idle = (random_bits(2) == 2'd0);

      while (issued < NUM_CMDS || exp_data_q.size() != 0)
      begin
         @(negedge clk);
         cmd_valid = 1'b0;
         check_response();
         if (cmd_credit)
         begin
            credits++;
            check_credits();
         end
         // A waiting command goes out only once everything before it has answered
         if (issued < NUM_CMDS && credits > 0 && !(wait_idle && exp_data_q.size() != 0))
         begin
            issue_command(wait_idle);
            wait_idle = (random_bits(2) == 2'd0);
         end
      end

      // Catch stray responses and late credits
      repeat (20)
      begin
         @(negedge clk);
         check_response();
         if (cmd_credit)
         begin
            credits++;
            check_credits();
         end
      end

      if (credits != CMD_DEPTH)
      begin
         credit_errors++;
         $display("The host ends with %0d credits instead of %0d", credits, CMD_DEPTH);
      end
      if (responses != NUM_CMDS)
      begin
         order_errors++;
         $display("Got %0d responses for %0d commands", responses, NUM_CMDS);
      end

      $display("Errors: data %0d, nxm %0d, latency %0d, credit %0d, order %0d",
               data_errors, nxm_errors, latency_errors, credit_errors, order_errors);
      if (data_errors + nxm_errors + latency_errors + credit_errors + order_errors == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("The run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
